/* verilog/rv32i_types.sv */
package rv32i_types;

    localparam int iq_depth         = 16;
    localparam int iq_addr_w        = $clog2(iq_depth);
    localparam int dispatch_credits = 4;
    localparam int disp_cnt_w       = $clog2(dispatch_credits + 1);   // holds 0..dispatch_credits

    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111
    } opcode_e;

    // one fetched word, read through whichever format the opcode implies
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            opcode_e    opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            opcode_e    opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            opcode_e     opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            opcode_e    opcode;
        } j_fmt;
    } instr_word_t;

    typedef enum logic [2:0] {
        alu_reg,
        alu_imm,
        mem_load,
        mem_store,
        ctrl_branch,
        ctrl_jump,
        upper_imm,
        op_illegal
    } uop_class_e;

    typedef struct packed {
        logic [31:0] pc;
        uop_class_e  uclass;
        logic [2:0]  funct3;
        logic        funct7_b5;   // sub/sra select
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;         // already sign-extended
    } decoded_uop_t;

endpackage : rv32i_types

/* verilog/fetch_if.sv */
`timescale 1ns/1ps

// one instruction entry moving between two internal stages
interface fetch_if;
    import rv32i_types::*;

    logic        valid;
    logic [31:0] pc;
    instr_word_t instr;

    modport src (
        output valid,
        output pc,
        output instr
    );

    modport dst (
        input valid,
        input pc,
        input instr
    );

endinterface : fetch_if

/* verilog/fetch_ingress.sv */
`timescale 1ns/1ps

module fetch_ingress (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     fetch_valid,
    input  logic [31:0]              fetch_pc,
    input  rv32i_types::instr_word_t fetch_instr,
    input  logic                     q_full,
    fetch_if.src                     out,
    output logic                     credit_error
);

    logic accept;    // beat moves on toward the queue
    logic overrun;   // fetch sent with no slot left

    assign accept  = fetch_valid && !q_full;
    assign overrun = fetch_valid && q_full && !flush;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out.valid <= 1'b0;   // flush drops the staged beat
        end else begin
            out.valid <= accept;
        end
    end

    // payload follows the accepted beat
    always_ff @(posedge clk) begin
        if (accept) begin
            out.pc    <= fetch_pc;
            out.instr <= fetch_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_error <= 1'b0;
        end else if (overrun) begin
            credit_error <= 1'b1;   // held until reset
        end
    end

endmodule : fetch_ingress

/* verilog/instr_queue.sv */
`timescale 1ns/1ps

module instr_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    fetch_if.dst                     in,
    input  logic                     deq,
    output rv32i_types::instr_word_t head,
    output logic [31:0]              head_pc,
    output logic                     empty,
    output logic                     full
);

    import rv32i_types::*;

    logic [31:0]        pc_mem    [iq_depth];
    instr_word_t        instr_mem [iq_depth];

    logic [iq_addr_w:0] head_ptr;   // top bit is the wrap flag
    logic [iq_addr_w:0] tail_ptr;   // top bit is the wrap flag
    logic [iq_addr_w:0] count;      // entries held
    logic               wrap_full;  // every slot written

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;   // flush wins over a same-cycle enqueue
            tail_ptr <= '0;
        end else begin
            if (in.valid) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (deq) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && !flush) begin
            pc_mem[tail_ptr[iq_addr_w-1:0]]    <= in.pc;
            instr_mem[tail_ptr[iq_addr_w-1:0]] <= in.instr;
        end
    end

    assign head    = instr_mem[head_ptr[iq_addr_w-1:0]];
    assign head_pc = pc_mem[head_ptr[iq_addr_w-1:0]];

    assign count     = tail_ptr - head_ptr;
    assign empty     = (tail_ptr == head_ptr);
    assign wrap_full = (tail_ptr[iq_addr_w] != head_ptr[iq_addr_w]) &&
                       (tail_ptr[iq_addr_w-1:0] == head_ptr[iq_addr_w-1:0]);

    // The beat staged in ingress already owns a slot, so the queue reads as full
    // one entry early while that beat is still on its way in.
    assign full = wrap_full ||
                  (in.valid && (count == (iq_addr_w + 1)'(iq_depth - 1)));

endmodule : instr_queue

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  rv32i_types::instr_word_t  head,
    input  logic [31:0]               head_pc,
    input  logic                      empty,
    output logic                      deq,
    input  logic                      dispatch_credit,
    output logic                      uop_valid,
    output rv32i_types::decoded_uop_t uop,
    output logic                      fetch_credit
);

    import rv32i_types::*;

    logic [disp_cnt_w-1:0] credits;   // free dispatch slots
    decoded_uop_t          dec;       // head word, decoded
    logic [31:0]           imm_i;
    logic [31:0]           imm_s;
    logic [31:0]           imm_b;
    logic [31:0]           imm_u;
    logic [31:0]           imm_j;
    logic                  is_shift;  // slli/srli/srai

    assign deq = !empty && (credits != '0) && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= disp_cnt_w'(dispatch_credits);
        end else if (deq && !dispatch_credit) begin
            credits <= credits - 1'b1;
        end else if (!deq && dispatch_credit) begin
            credits <= credits + 1'b1;   // flush leaves the count alone
        end
    end

    assign imm_i = {{20{head.i_fmt.imm[11]}}, head.i_fmt.imm};
    assign imm_s = {{20{head.s_fmt.imm_11_5[6]}}, head.s_fmt.imm_11_5, head.s_fmt.imm_4_0};
    assign imm_b = {{19{head.b_fmt.imm_12}}, head.b_fmt.imm_12, head.b_fmt.imm_11,
                    head.b_fmt.imm_10_5, head.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {head.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{head.j_fmt.imm_20}}, head.j_fmt.imm_20, head.j_fmt.imm_19_12,
                    head.j_fmt.imm_11, head.j_fmt.imm_10_1, 1'b0};

    assign is_shift = (head.r_fmt.funct3 == 3'd1) || (head.r_fmt.funct3 == 3'd5);

    // start from the raw register fields, then clear what the class does not use
    always_comb begin
        dec           = '0;
        dec.pc        = head_pc;
        dec.funct3    = head.r_fmt.funct3;
        dec.rd        = head.r_fmt.rd;
        dec.rs1       = head.r_fmt.rs1;
        dec.rs2       = head.r_fmt.rs2;
        case (head.r_fmt.opcode)
            op: begin
                dec.uclass    = alu_reg;
                dec.funct7_b5 = head.r_fmt.funct7[5];
            end
            op_imm: begin
                dec.uclass    = alu_imm;
                dec.rs2       = '0;
                dec.imm       = imm_i;
                dec.funct7_b5 = is_shift ? head.r_fmt.funct7[5] : 1'b0;
            end
            load: begin
                dec.uclass = mem_load;
                dec.rs2    = '0;
                dec.imm    = imm_i;
            end
            store: begin
                dec.uclass = mem_store;
                dec.rd     = '0;
                dec.imm    = imm_s;
            end
            branch: begin
                dec.uclass = ctrl_branch;
                dec.rd     = '0;
                dec.imm    = imm_b;
            end
            jal: begin
                dec.uclass = ctrl_jump;
                dec.rs1    = '0;
                dec.rs2    = '0;
                dec.imm    = imm_j;
            end
            jalr: begin
                dec.uclass = ctrl_jump;
                dec.rs2    = '0;
                dec.imm    = imm_i;
            end
            lui, auipc: begin
                dec.uclass = upper_imm;
                dec.rs1    = '0;
                dec.rs2    = '0;
                dec.imm    = imm_u;
            end
            default: begin
                dec        = '0;   // only the pc survives
                dec.pc     = head_pc;
                dec.uclass = op_illegal;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uop_valid    <= 1'b0;
            fetch_credit <= 1'b0;
        end else begin
            uop_valid    <= deq;
            fetch_credit <= deq;   // one freed queue slot
        end
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            uop <= dec;
        end
    end

endmodule : decode_stage

/* verilog/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      fetch_valid,
    input  logic [31:0]               fetch_pc,
    input  rv32i_types::instr_word_t  fetch_instr,
    output logic                      fetch_credit,
    output logic                      uop_valid,
    output rv32i_types::decoded_uop_t uop,
    input  logic                      dispatch_credit,
    output logic                      credit_error
);

    logic                     q_full;
    logic                     q_empty;
    logic                     q_deq;
    rv32i_types::instr_word_t q_head;
    logic [31:0]              q_head_pc;

    fetch_if ingress_to_queue ();   // staged beat into the queue

    fetch_ingress u_ingress (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_instr  (fetch_instr),
        .q_full       (q_full),
        .out          (ingress_to_queue.src),
        .credit_error (credit_error)
    );

    instr_queue u_queue (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .in      (ingress_to_queue.dst),
        .deq     (q_deq),
        .head    (q_head),
        .head_pc (q_head_pc),
        .empty   (q_empty),
        .full    (q_full)
    );

    decode_stage u_decode (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .head            (q_head),
        .head_pc         (q_head_pc),
        .empty           (q_empty),
        .deq             (q_deq),
        .dispatch_credit (dispatch_credit),
        .uop_valid       (uop_valid),
        .uop             (uop),
        .fetch_credit    (fetch_credit)
    );

endmodule : frontend_top

/* test/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule : clock_gen

/* test/frontend_properties.sv */
`timescale 1ns/1ps

module frontend_properties (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic uop_valid,
    input logic fetch_credit,
    input logic dispatch_credit,
    input logic q_full,
    input logic q_empty
);

    import rv32i_types::*;

    logic [3:0] in_dispatch;   // uops dispatch holds and has not freed

    always_ff @(posedge clk) begin
        if (rst) begin
            in_dispatch <= '0;
        end else begin
            in_dispatch <= in_dispatch + 4'(uop_valid) - 4'(dispatch_credit);
        end
    end

    no_issue_without_credit: assert property (
        @(posedge clk) disable iff (rst) in_dispatch <= 4'(dispatch_credits)
    ) else $error("uop issued with no dispatch credit left");

    no_credit_after_flush: assert property (
        @(posedge clk) disable iff (rst) flush |=> !fetch_credit
    ) else $error("fetch credit returned in the cycle after a flush");

    // one dequeue per cycle cannot take a full queue down to empty
    full_not_emptied: assert property (
        @(posedge clk) disable iff (rst) q_full && !flush |=> !q_empty
    ) else $error("queue went from full to empty without a flush");

endmodule : frontend_properties

bind frontend_top frontend_properties props (
    .clk             (clk),
    .rst             (rst),
    .flush           (flush),
    .uop_valid       (uop_valid),
    .fetch_credit    (fetch_credit),
    .dispatch_credit (dispatch_credit),
    .q_full          (q_full),
    .q_empty         (q_empty)
);

/* test/frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb;
    import rv32i_types::*;

    localparam int beats_total  = 40 + 12 + 10 + 20 + 24 + 21;   // all beats the tests send
    localparam int watchdog_cyc = beats_total * 40 + 400;
    localparam logic [6:0] opcode_list [10] = '{op, op_imm, load, store, branch,
                                                lui, auipc, jal, jalr, 7'b1110011};

    logic         clk;
    logic         rst;
    logic         flush;
    logic         fetch_valid;
    logic [31:0]  fetch_pc;
    instr_word_t  fetch_instr;
    logic         fetch_credit;
    logic         uop_valid;
    decoded_uop_t uop;
    logic         dispatch_credit;
    logic         credit_error;

    integer       seed;
    int           errors;
    int           fetch_cnt;      // credits fetch still holds
    int           outstanding;    // uops dispatch has not freed yet
    int           uops_seen;
    int           credits_back;
    bit           release_on;     // dispatch frees each uop right away
    logic [31:0]  next_pc;
    decoded_uop_t expected_q [$];

    clock_gen clk_src (.clk(clk), .rst(rst));

    frontend_top UUT (
        .clk             (clk),
        .rst             (rst),
        .flush           (flush),
        .fetch_valid     (fetch_valid),
        .fetch_pc        (fetch_pc),
        .fetch_instr     (fetch_instr),
        .fetch_credit    (fetch_credit),
        .uop_valid       (uop_valid),
        .uop             (uop),
        .dispatch_credit (dispatch_credit),
        .credit_error    (credit_error)
    );

    // reference decode straight from the RV32I bit layout
    function automatic decoded_uop_t ref_decode(input logic [31:0] w, input logic [31:0] pc);
        decoded_uop_t u;
        logic [31:0]  imm_i;
        imm_i    = {{20{w[31]}}, w[31:20]};
        u        = '0;
        u.pc     = pc;
        u.funct3 = w[14:12];
        u.rd     = w[11:7];
        u.rs1    = w[19:15];
        u.rs2    = w[24:20];
        case (w[6:0])
            op: begin
                u.uclass    = alu_reg;
                u.funct7_b5 = w[30];
            end
            op_imm: begin
                u.uclass    = alu_imm;
                u.rs2       = '0;
                u.imm       = imm_i;
                u.funct7_b5 = (w[14:12] == 3'd1 || w[14:12] == 3'd5) ? w[30] : 1'b0;
            end
            load: begin
                u.uclass = mem_load;
                u.rs2    = '0;
                u.imm    = imm_i;
            end
            store: begin
                u.uclass = mem_store;
                u.rd     = '0;
                u.imm    = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            branch: begin
                u.uclass = ctrl_branch;
                u.rd     = '0;
                u.imm    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            jal: begin
                u.uclass = ctrl_jump;
                u.rs1    = '0;
                u.rs2    = '0;
                u.imm    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            jalr: begin
                u.uclass = ctrl_jump;
                u.rs2    = '0;
                u.imm    = imm_i;
            end
            lui, auipc: begin
                u.uclass = upper_imm;
                u.rs1    = '0;
                u.rs2    = '0;
                u.imm    = {w[31:12], 12'b0};
            end
            default: begin
                u        = '0;
                u.pc     = pc;
                u.uclass = op_illegal;
            end
        endcase
        return u;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        int          pick;
        w      = $random(seed);
        pick   = $unsigned($random(seed)) % 10;
        w[6:0] = opcode_list[pick];
        return w;
    endfunction

    task automatic compare_uop(input string name, input decoded_uop_t got,
                               input decoded_uop_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // one cycle: sample outputs at the falling edge, then drive dispatch
    task automatic tick();
        @(negedge clk);
        if (uop_valid) begin
            uops_seen++;
            outstanding++;
            if (expected_q.size() == 0) begin
                errors++;
                $display("uop with pc %h came out while none was pending", uop.pc);
            end else begin
                compare_uop("uop", uop, expected_q.pop_front());
            end
        end
        if (fetch_credit) begin
            fetch_cnt++;
            credits_back++;
        end
        if (fetch_cnt > iq_depth) begin
            errors++;
            $display("fetch got back more credits than the queue has slots");
        end
        dispatch_credit = 1'b0;
        if (release_on && outstanding > 0) begin
            dispatch_credit = 1'b1;
            outstanding--;
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        while (fetch_cnt == 0) tick();   // fetch may only send on a credit
        fetch_valid = 1'b1;
        fetch_pc    = next_pc;
        fetch_instr = w;
        expected_q.push_back(ref_decode(w, next_pc));
        fetch_cnt--;
        next_pc += 32'd4;
        tick();
        fetch_valid = 1'b0;
    endtask

    task automatic wait_drained(input string what);
        int n;
        n = 0;
        while ((expected_q.size() != 0 || outstanding != 0) && n < 400) begin
            tick();
            n++;
        end
        if (expected_q.size() != 0) begin
            errors++;
            $display("%s: %0d uops never came out", what, expected_q.size());
        end
        repeat (2) tick();
    endtask

    task automatic test_stream();
        release_on = 1'b1;
        repeat (40) send_word(random_word());
        wait_drained("stream");
        compare_count("fetch credits", fetch_cnt, iq_depth);
    endtask

    task automatic test_classes();
        logic [31:0] words [12];
        // sub addi srai lw sw beq jal jalr lui auipc ecall fence
        words = '{32'h402081b3, 32'hfff30293, 32'h40345393, 32'hff852483,
                  32'hfeb62e23, 32'hfe2088e3, 32'h800000ef, 32'h00c08067,
                  32'habcde137, 32'h80001217, 32'h00000073, 32'h0ff0000f};
        release_on = 1'b1;
        foreach (words[i]) send_word(words[i]);
        wait_drained("classes");
    endtask

    task automatic test_backpressure();
        int base;
        release_on = 1'b0;
        base       = uops_seen;
        repeat (10) send_word(random_word());
        repeat (20) tick();
        compare_count("uops while stalled", uops_seen - base, dispatch_credits);
        repeat (10 - dispatch_credits) begin
            base            = uops_seen;
            dispatch_credit = 1'b1;   // free exactly one slot
            outstanding--;
            repeat (6) tick();
            compare_count("uops per credit", uops_seen - base, 1);
        end
        release_on = 1'b1;
        wait_drained("backpressure");
    endtask

    task automatic test_credit_return();
        int base_uops;
        int base_back;
        release_on = 1'b0;
        compare_count("fetch credits at start", fetch_cnt, iq_depth);
        base_uops = uops_seen;
        base_back = credits_back;
        repeat (iq_depth + dispatch_credits) send_word(random_word());
        repeat (10) tick();
        compare_count("fetch credits left", fetch_cnt, 0);
        release_on = 1'b1;
        wait_drained("credit return");
        compare_count("credits returned", credits_back - base_back, uops_seen - base_uops);
        compare_count("fetch credits at end", fetch_cnt, iq_depth);
    endtask

    task automatic test_flush();
        release_on = 1'b0;
        repeat (7) send_word(random_word());
        dispatch_credit = 1'b1;   // decode holds a credit when the flush lands
        outstanding--;
        send_word(random_word());   // last beat still in ingress
        flush = 1'b1;
        expected_q.delete();
        fetch_cnt = iq_depth;   // fetch restarts its own count
        tick();
        flush = 1'b0;
        compare_bit("uop_valid", uop_valid, 1'b0);
        compare_bit("fetch_credit", fetch_credit, 1'b0);
        release_on = 1'b1;
        repeat (iq_depth) send_word(random_word());
        wait_drained("after flush");
        compare_count("fetch credits after flush", fetch_cnt, iq_depth);
    endtask

    task automatic test_overrun();
        release_on = 1'b0;
        compare_bit("credit_error", credit_error, 1'b0);
        repeat (iq_depth + dispatch_credits) send_word(random_word());
        repeat (10) tick();
        fetch_valid = 1'b1;   // no credit left
        fetch_pc    = 32'hdead_0000;
        fetch_instr = random_word();
        tick();
        fetch_valid = 1'b0;
        compare_bit("credit_error", credit_error, 1'b1);
        release_on = 1'b1;
        wait_drained("overrun");
    endtask

    initial begin
        seed            = 32'hac073bdf;
        errors          = 0;
        fetch_cnt       = iq_depth;
        outstanding     = 0;
        uops_seen       = 0;
        credits_back    = 0;
        release_on      = 1'b1;
        next_pc         = 32'h0000_1000;
        flush           = 1'b0;
        fetch_valid     = 1'b0;
        fetch_pc        = '0;
        fetch_instr     = '0;
        dispatch_credit = 1'b0;
        @(negedge clk);
        while (rst) @(negedge clk);
        compare_bit("uop_valid", uop_valid, 1'b0);
        compare_bit("fetch_credit", fetch_credit, 1'b0);
        compare_bit("credit_error", credit_error, 1'b0);
        test_stream();
        test_classes();
        test_backpressure();
        test_credit_return();
        test_flush();
        test_overrun();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cyc) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests finished", watchdog_cyc);
        $display("Done: errors found");
        $finish;
    end

endmodule : frontend_tb

/* files.f */
verilog/rv32i_types.sv
verilog/fetch_if.sv
verilog/fetch_ingress.sv
verilog/instr_queue.sv
verilog/decode_stage.sv
verilog/frontend_top.sv
test/clock_gen.sv
test/frontend_properties.sv
test/frontend_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module frontend_tb \
    -o frontend_sim \
    && ./obj_dir/frontend_sim 2>&1 | tee "$log" \
    || { echo "build or simulation failed"; exit 1; }

grep -q "Done: errors found" "$log" && { echo "testbench reported errors"; exit 1; }
grep -q "Done: no errors" "$log" || { echo "no pass line in the log"; exit 1; }
echo "simulation passed"
